// ==== Bender.yml ====
package:
  name: ifetch

sources:
  - common/ifetch_pkg.sv
  - verilog/fetch_ctrl.sv
  - verilog/fetch_addr_ctr.sv
  - verilog/imem.sv
  - iprefetch/iprefetch.sv
  - verilog/ifetch_top.sv
  - target: test
    files:
      - dv/ifetch_checker.sv
      - dv/ifetch_assert.sv
      - dv/ifetch_tb.sv

// ==== common/ifetch_pkg.sv ====
// Shared widths, controller states and bundles for the instruction fetch front end.

package ifetch_pkg;

    localparam int XLEN       = 32;                   // Address and instruction width.
    localparam int TAG_W      = 3;                    // Redirect tag width.
    localparam int IMEM_WORDS = 256;                  // Instruction memory depth.
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);   // Word index width.
    localparam int WORD_BYTES = 4;                    // Step for a 32-bit fetch.
    localparam int HALF_BYTES = 2;                    // Step for a compressed instruction.

    // Fetch controller states.
    typedef enum logic [1:0] {
        FS_IDLE,                                      // Not fetching.
        FS_REDIRECT,                                  // First read after start or jump.
        FS_ALIGN,                                     // Fill cycle for an odd halfword target.
        FS_STREAM                                     // Steady fetch.
    } fetch_state_e;

    // Request from the controller to the counter and the prefetcher.
    typedef struct packed {
        logic             enable;                     // Fetching is active.
        logic             stall;                      // Pipeline hold.
        logic             jumped;                     // First cycle after a redirect.
        logic             jump_misaligned;            // Target has bit 1 set.
        logic [TAG_W-1:0] tag;                        // Redirect tag.
        logic [XLEN-1:0]  pc;                         // Redirect target.
    } fetch_req_t;

    // One fetched instruction.
    typedef struct packed {
        logic             valid;
        logic             compressed;                 // 16-bit instruction in instr[15:0].
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  instr;
    } fetch_out_t;

    // Instruction memory write port.
    typedef struct packed {
        logic               we;
        logic [IMEM_AW-1:0] addr;                     // Word index.
        logic [XLEN-1:0]    data;
    } imem_wr_t;

endpackage

// ==== dv/ifetch_assert.sv ====
// Bound assertions on the fetch controller state and the prefetcher output.

module ifetch_assert import ifetch_pkg::*; (
    input logic             clk,
    input logic             reset_n,
    input fetch_state_e     state_i,
    input logic             stall_i,
    input logic [TAG_W-1:0] tag_i,
    input fetch_out_t       fetch_i
);

    // The output register drains one cycle after the controller leaves FS_STREAM.
    valid_only_streaming: assert property (@(posedge clk) disable iff (!reset_n)
        (state_i != FS_STREAM) |=> !fetch_i.valid)
        else $error("Output valid after a cycle outside FS_STREAM");

    stall_holds_fields: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> $stable({fetch_i.compressed, fetch_i.tag, fetch_i.pc, fetch_i.instr}))
        else $error("Output fields changed across a stall");

    tag_follows_ctrl: assert property (@(posedge clk) disable iff (!reset_n)
        fetch_i.valid |-> (fetch_i.tag == tag_i))
        else $error("Output tag differs from the controller tag");

endmodule

bind ifetch_top ifetch_assert u_assert (
    .clk         (clk),
    .reset_n     (reset_n),
    .state_i     (u_fetch_ctrl.state_r),
    .stall_i     (stall_i),
    .tag_i       (u_fetch_ctrl.tag_r),
    .fetch_i     (u_iprefetch.out_o)
);

// ==== dv/ifetch_checker.sv ====
// Reference model that walks a memory copy and compares each fetched instruction.

module ifetch_checker import ifetch_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  imem_wr_t        imem_wr_i,
    input  logic            start_i,
    input  logic [XLEN-1:0] start_pc_i,
    input  logic            stall_i,
    input  fetch_out_t      fetch_i,
    output int              stream_count_o,
    output int              error_count_o
);

    logic [XLEN-1:0] mem_copy [IMEM_WORDS];
    logic [XLEN-1:0] exp_pc  = '0;                    // Next instruction expected.
    int              starts  = 0;
    logic            started = 1'b0;

    initial begin
        stream_count_o = 0;
        error_count_o  = 0;
    end

    function automatic logic [15:0] half_at(logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        word = mem_copy[addr[IMEM_AW+1:2]];
        return addr[1] ? word[31:16] : word[15:0];
    endfunction

    task automatic report(string msg);
        $display("FAILED at %0t: %s", $time, msg);
        error_count_o++;
    endtask

    task automatic check_output();
        logic [15:0]     lo;
        logic [XLEN-1:0] exp_instr;
        logic            exp_comp;
        lo        = half_at(exp_pc);
        exp_comp  = (lo[1:0] != 2'b11);               // Only 11 marks a 32-bit instruction.
        exp_instr = {half_at(exp_pc + XLEN'(2)), lo};
        if (stall_i) begin
            report("valid output while stalled");
        end
        if (!started) begin
            report("valid output before the first start");
        end else begin
            if (fetch_i.pc !== exp_pc) begin
                report($sformatf("pc %h, expected %h", fetch_i.pc, exp_pc));
            end
            if (fetch_i.compressed !== exp_comp) begin
                report($sformatf("compressed %b at pc %h", fetch_i.compressed, exp_pc));
            end
            if (exp_comp) begin
                if (fetch_i.instr[15:0] !== lo) begin
                    report($sformatf("instr %h at pc %h, expected %h",
                                     fetch_i.instr[15:0], exp_pc, lo));
                end
            end else if (fetch_i.instr !== exp_instr) begin
                report($sformatf("instr %h at pc %h, expected %h",
                                 fetch_i.instr, exp_pc, exp_instr));
            end
            if (fetch_i.tag !== TAG_W'(starts)) begin
                report($sformatf("tag %0d at pc %h", fetch_i.tag, exp_pc));
            end
            exp_pc = exp_pc + (exp_comp ? XLEN'(2) : XLEN'(4));
            stream_count_o++;
        end
    endtask

    // Old stream output in the start cycle is checked before the new target takes over.
    always @(negedge clk) begin
        if (imem_wr_i.we === 1'b1) begin
            mem_copy[imem_wr_i.addr] = imem_wr_i.data;
        end
        if (reset_n) begin
            if (fetch_i.valid === 1'b1) begin
                check_output();
            end
            if (start_i) begin
                exp_pc         = start_pc_i;
                starts         = starts + 1;
                started        = 1'b1;
                stream_count_o = 0;
            end
        end
    end

endmodule

// ==== dv/ifetch_stim.txt ====
# W word_index(hex) data(hex) | S pc(hex) count(dec) | H stall_cycles(0 = random) | P stop
# Programs overlay a fill pattern that covers the whole memory.
W 00 00000013
W 01 00100093
W 02 00208113
W 03 003101b3
W 10 05054501
W 11 46014581
W 12 0509c64a
W 20 05934501
W 21 050500a0
W 22 02b50533
W 23 80934581
W 24 80820010
S 000 4
P
S 040 6
S 042 5
P
S 080 7
S 082 4
S 086 3
S 080 3
H 3
H 0
H 0
P
S 100 20
H 0
H 0
P
S 0f2 12
H 5
P

// ==== dv/ifetch_tb.sv ====
// Testbench top for the instruction fetch front end, driven by a command file.

module ifetch_tb import ifetch_pkg::*; ();

    logic            clk = 1'b0;
    logic            reset_n;
    imem_wr_t        imem_wr;
    logic            start;
    logic [XLEN-1:0] start_pc;
    logic            stop;
    logic            stall;
    fetch_out_t      fetch;
    int              stream_count;
    int              chk_errors;
    int              tb_errors = 0;

    always #2 clk = ~clk;                             // Period of 4.

    ifetch_top uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .imem_wr_i  (imem_wr),
        .start_i    (start),
        .start_pc_i (start_pc),
        .stop_i     (stop),
        .stall_i    (stall),
        .fetch_o    (fetch)
    );

    ifetch_checker u_checker (
        .clk            (clk),
        .reset_n        (reset_n),
        .imem_wr_i      (imem_wr),
        .start_i        (start),
        .start_pc_i     (start_pc),
        .stall_i        (stall),
        .fetch_i        (fetch),
        .stream_count_o (stream_count),
        .error_count_o  (chk_errors)
    );

    task automatic step();
        @(posedge clk);
        #1;                                           // Drive just after the edge.
    endtask

    // Background pattern spread over the whole word index.
    function automatic logic [XLEN-1:0] fill_word(int idx);
        logic [7:0] i;
        i = idx[7:0];
        return {i ^ 8'h5a, i, ~i, i * 8'd3};
    endfunction

    task automatic write_word(int idx, logic [XLEN-1:0] data);
        imem_wr.we   = 1'b1;
        imem_wr.addr = IMEM_AW'(idx);
        imem_wr.data = data;
        step();
        imem_wr.we   = 1'b0;
    endtask

    task automatic stall_for(int n);
        stall = 1'b1;
        repeat (n) step();
        stall = 1'b0;
    endtask

    task automatic random_stall();
        int n;
        n = $urandom % 4;
        if (n > 0) begin
            stall_for(n);
        end
    endtask

    task automatic stop_stream();
        stop = 1'b1;
        step();
        stop = 1'b0;
    endtask

    task automatic start_stream(logic [XLEN-1:0] pc, int count);
        int cycles;
        int limit;
        limit    = 8 * count + 20;
        cycles   = 0;
        start    = 1'b1;
        start_pc = pc;
        step();
        start    = 1'b0;
        while (stream_count < count && cycles < limit) begin
            step();
            cycles++;
        end
        if (stream_count < count) begin
            $display("Timed out after %0d cycles waiting for %0d instructions from pc %h",
                     cycles, count, pc);
            tb_errors++;
        end
    endtask

    initial begin
        string cmd;
        string line;
        int    fd;
        int    code;
        int    a;
        int    b;
        int    n;
        reset_n  = 1'b0;
        imem_wr  = '0;
        start    = 1'b0;
        start_pc = '0;
        stop     = 1'b0;
        stall    = 1'b0;
        code     = $urandom(32'heec4);
        repeat (5) step();
        reset_n = 1'b1;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            write_word(i, fill_word(i));
        end
        fd = $fopen("dv/ifetch_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/ifetch_stim.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", cmd);
                if (code == 1) begin
                    case (cmd)
                        "#": code = $fgets(line, fd);   // Rest of a comment line.
                        "W": begin
                            code = $fscanf(fd, "%h %h", a, b);
                            write_word(a, b);
                        end
                        "S": begin
                            code = $fscanf(fd, "%h %d", a, n);
                            start_stream(a, n);
                            random_stall();
                        end
                        "H": begin
                            code = $fscanf(fd, "%d", n);
                            if (n == 0) begin
                                n = 1 + $urandom % 6;
                            end
                            stall_for(n);
                        end
                        "P": stop_stream();
                        default: begin
                            $display("Unknown command %s in the stimulus file", cmd);
                            tb_errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        repeat (8) step();                            // Drain the last outputs.
        $display("Checker errors: %0d, testbench errors: %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== ifetch.f ====
common/ifetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/fetch_addr_ctr.sv
verilog/imem.sv
iprefetch/iprefetch.sv
verilog/ifetch_top.sv
dv/ifetch_checker.sv
dv/ifetch_assert.sv
dv/ifetch_tb.sv

// ==== iprefetch/iprefetch.sv ====
// Prefetch buffer and halfword realigner that assembles whole instructions from memory words.

module iprefetch import ifetch_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  fetch_req_t      req_i,
    input  logic            valid_i,
    input  logic [XLEN-1:0] instruction_i,
    output logic            prefetched_o,
    output fetch_out_t      out_o
);

    logic [XLEN-1:0]  pc_r;                           // PC of the next instruction to issue.
    logic [XLEN-1:0]  pc_next;
    logic [XLEN-1:0]  pc_add;
    logic             misaligned;
    logic             compressed;
    logic             capture;

    // Previous word whose upper half starts an odd halfword instruction.
    logic [XLEN-1:0]  instruction_r;
    logic [XLEN-1:0]  instruction_aligned;
    logic [XLEN-1:0]  instruction_spliced;
    logic [XLEN-1:0]  instruction;

    logic             valid_r;
    logic             compressed_r;
    logic [TAG_W-1:0] tag_r;
    logic [XLEN-1:0]  pc_out_r;
    logic [XLEN-1:0]  instr_out_r;

    assign misaligned = pc_r[1];

    assign instruction_aligned = instruction_i;
    assign instruction_spliced = {instruction_i[15:0], instruction_r[31:16]};

    always_comb begin
        if (misaligned) begin
            instruction = instruction_spliced;        // Buffered half first.
        end else begin
            instruction = instruction_aligned;
        end
    end

    assign compressed = (instruction[1:0] != 2'b11);

    assign pc_add  = compressed ? XLEN'(HALF_BYTES) : XLEN'(WORD_BYTES);
    assign pc_next = pc_r + pc_add;

    // A compressed instruction from the buffer leaves the incoming word unused.
    assign prefetched_o = valid_i && misaligned && compressed;

    // Any live, non-stalled cycle past the redirect keeps the newest word.
    assign capture = req_i.enable && !req_i.stall && !req_i.jumped;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_r <= '0;
        end else if (req_i.jumped) begin
            pc_r <= req_i.pc;
        end else if (valid_i) begin
            pc_r <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_r <= '0;
        end else if (capture) begin
            instruction_r <= instruction_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_r <= 1'b0;
        end else if (req_i.jumped || !req_i.enable) begin
            valid_r <= 1'b0;                          // Drop anything left from the old stream.
        end else if (!req_i.stall) begin
            valid_r <= valid_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            compressed_r <= 1'b0;
            tag_r        <= '0;
            pc_out_r     <= '0;
            instr_out_r  <= '0;
        end else if (valid_i) begin
            compressed_r <= compressed;
            tag_r        <= req_i.tag;
            pc_out_r     <= pc_r;
            instr_out_r  <= instruction;
        end
    end

    // Held instruction stays hidden while stalled and shows once the stall ends.
    assign out_o = '{
        valid:      valid_r && !req_i.stall,
        compressed: compressed_r,
        tag:        tag_r,
        pc:         pc_out_r,
        instr:      instr_out_r
    };

endmodule

// ==== verilog/fetch_addr_ctr.sv ====
// Word fetch address counter with redirect load and hold on stall or buffer hit.

module fetch_addr_ctr import ifetch_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  fetch_req_t      req_i,
    input  logic            prefetched_i,
    output logic [XLEN-1:0] addr_o
);

    logic [XLEN-1:0] cur_addr_r;                      // Address of the word now on the read port.
    logic            advance;

    // The word on the read port is used up this cycle.
    assign advance = req_i.enable && !req_i.stall && !prefetched_i;

    always_comb begin
        if (req_i.jumped) begin
            addr_o = {req_i.pc[XLEN-1:2], 2'b00};     // Word holding the target.
        end else if (advance) begin
            addr_o = cur_addr_r + XLEN'(WORD_BYTES);
        end else begin
            // Read the same word again so it is still there next cycle.
            addr_o = cur_addr_r;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cur_addr_r <= '0;
        end else begin
            cur_addr_r <= addr_o;
        end
    end

endmodule

// ==== verilog/fetch_ctrl.sv ====
// Fetch controller FSM that sequences start, redirect, alignment fill and streaming.

module fetch_ctrl import ifetch_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            start_i,
    input  logic [XLEN-1:0] start_pc_i,
    input  logic            stop_i,
    input  logic            stall_i,
    input  logic            prefetched_i,
    output fetch_req_t      req_o,
    output logic            out_valid_o
);

    fetch_state_e     state_r;
    fetch_state_e     state_d;
    logic [TAG_W-1:0] tag_r;
    logic [XLEN-1:0]  target_r;
    logic             stop_pend_r;
    logic             stop_pend_d;
    logic             stop_req;

    assign stop_req = stop_i | stop_pend_r;

    always_comb begin
        state_d     = state_r;
        stop_pend_d = 1'b0;
        if (start_i) begin
            state_d = FS_REDIRECT;                    // A new target wins, even under stall.
        end else begin
            case (state_r)
                FS_IDLE: begin
                    state_d = FS_IDLE;
                end
                FS_REDIRECT: begin
                    if (stop_i) begin
                        state_d = FS_IDLE;
                    end else if (req_o.jump_misaligned) begin
                        state_d = FS_ALIGN;           // Lower half of the first word is dropped.
                    end else begin
                        state_d = FS_STREAM;
                    end
                end
                FS_ALIGN: begin
                    if (stop_i) begin
                        state_d = FS_IDLE;
                    end else if (!stall_i) begin
                        state_d = FS_STREAM;
                    end
                end
                FS_STREAM: begin
                    // Let a buffered compressed instruction drain before stopping.
                    if (stop_req && prefetched_i) begin
                        stop_pend_d = 1'b1;
                    end else if (stop_req) begin
                        state_d = FS_IDLE;
                    end
                end
                default: begin
                    state_d = FS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_r     <= FS_IDLE;
            tag_r       <= '0;
            target_r    <= '0;
            stop_pend_r <= 1'b0;
        end else begin
            state_r     <= state_d;
            stop_pend_r <= stop_pend_d;
            if (start_i) begin
                tag_r    <= tag_r + TAG_W'(1);        // Wraps modulo 8.
                target_r <= start_pc_i;
            end
        end
    end

    assign req_o.enable          = (state_r != FS_IDLE);
    assign req_o.stall           = stall_i;
    assign req_o.jumped          = (state_r == FS_REDIRECT);
    assign req_o.jump_misaligned = target_r[1];
    assign req_o.tag             = tag_r;
    assign req_o.pc              = target_r;

    // Memory data lags the address by one cycle, so only FS_STREAM sees usable words.
    assign out_valid_o = (state_r == FS_STREAM) && !stall_i && !start_i;

endmodule

// ==== verilog/ifetch_top.sv ====
// Instruction fetch front end top level joining controller, counter, memory and prefetcher.

module ifetch_top import ifetch_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    input  imem_wr_t        imem_wr_i,
    input  logic            start_i,
    input  logic [XLEN-1:0] start_pc_i,
    input  logic            stop_i,
    input  logic            stall_i,
    output fetch_out_t      fetch_o
);

    fetch_req_t      req;
    logic            prefetched;
    logic            out_valid;
    logic [XLEN-1:0] fetch_addr;
    logic [XLEN-1:0] imem_rdata;

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .start_pc_i   (start_pc_i),
        .stop_i       (stop_i),
        .stall_i      (stall_i),
        .prefetched_i (prefetched),
        .req_o        (req),
        .out_valid_o  (out_valid)
    );

    fetch_addr_ctr u_fetch_addr_ctr (
        .clk          (clk),
        .reset_n      (reset_n),
        .req_i        (req),
        .prefetched_i (prefetched),
        .addr_o       (fetch_addr)
    );

    imem u_imem (
        .clk     (clk),
        .wr_i    (imem_wr_i),
        .addr_i  (fetch_addr),
        .rdata_o (imem_rdata)
    );

    iprefetch u_iprefetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_i         (req),
        .valid_i       (out_valid),
        .instruction_i (imem_rdata),
        .prefetched_o  (prefetched),
        .out_o         (fetch_o)
    );

endmodule

// ==== verilog/imem.sv ====
// Synchronous instruction memory with a write strobe port and a one-cycle read.

module imem import ifetch_pkg::*; (
    input  logic            clk,
    input  imem_wr_t        wr_i,
    input  logic [XLEN-1:0] addr_i,
    output logic [XLEN-1:0] rdata_o
);

    logic [XLEN-1:0]    mem [IMEM_WORDS];
    logic [IMEM_AW-1:0] rd_idx;

    assign rd_idx = addr_i[IMEM_AW+1:2];              // Byte address to word index.

    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // Registered read with one cycle of latency.
    always_ff @(posedge clk) begin
        rdata_o <= mem[rd_idx];
    end

endmodule
